// ==== Makefile ====
# Verilator build and run of the receive queue testbench

VERILATOR ?= verilator
TOP       ?= tb_rx_queue
SEED      ?= 51596
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

# Build, run, and pass only if the pass message shows up in the output
sim:
	$(VERILATOR) $(VFLAGS) --Mdir $(OBJ_DIR) --top-module $(TOP) -GSEED=$(SEED) -f build.f
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "No errors"

clean:
	rm -rf $(OBJ_DIR)

// ==== bench/tb_clock.sv ====
// Testbench clock source; free-running clk with a 10 ns period for the receive queue bench
`default_nettype none

module tb_clock (
   output logic clk
);

   timeunit 1ns;
   timeprecision 1ps;

   localparam int HALF_PERIOD = 5;  // ns

   initial begin
      clk = 1'b0;
      forever #HALF_PERIOD clk = ~clk;  // Runs until $finish
   end

endmodule

`default_nettype wire

// ==== bench/tb_rx_queue.sv ====
// Receive queue testbench; drives MAC frames into rx_queue_top and checks the output stream
`default_nettype none

module tb_rx_queue #(
   parameter int SEED = 32'hc98c  // Start value for $random
);

   timeunit 1ns;
   timeprecision 1ps;

   import mac_rx_pkg::*;
   import stream_pkg::*;

   localparam int RANDOM_FRAMES   = 30;
   localparam int ONE_BYTE_FRAMES = 8;
   localparam int FILL_LEN        = 40;                               // Test 5 frame length
   localparam int MAX_FILL_FRAMES = DATA_FIFO_DEPTH / (FILL_LEN + 1); // Upper bound to threshold
   localparam int EXTRA_DROPS     = 2;
   localparam int NUM_FRAMES      = 1 + 2 + RANDOM_FRAMES + ONE_BYTE_FRAMES
                                    + MAX_FILL_FRAMES + 1 + EXTRA_DROPS + 1;
   localparam int WATCHDOG_CYCLES = 200 * NUM_FRAMES + 1000;
   localparam int DRAIN_LIMIT     = 4000;  // Cycles to empty the model queue
   localparam int BACKLOG_LIMIT   = 40;    // Keeps FIFO count below the drop threshold

   logic         clk;
   logic         reset;
   mac_rx_beat_t mac_rx;
   logic         rx_good_frame;
   logic         rx_bad_frame;
   logic         tready;
   stream_beat_t m_beat;
   logic         tvalid;
   logic         err_tvalid;

   // Expected output, one entry per beat
   stream_beat_t exp_beats[$];
   logic         exp_errs[$];

   integer seed       = SEED;
   integer ready_seed = SEED + 1;  // Separate stream for tready
   logic   ready_rand = 1'b0;      // Random tready when set
   logic   ready_level = 1'b1;     // Fixed tready otherwise

   int beat_errors  = 0;
   int err_errors   = 0;
   int other_errors = 0;
   int frames_sent  = 0;

   tb_clock tb_clock_i (.clk(clk));

   rx_queue_top rx_queue_top_i (
      .clk, .reset, .mac_rx, .rx_good_frame, .rx_bad_frame,
      .tready, .m_beat, .tvalid, .err_tvalid
   );

   task automatic check_beat(input stream_beat_t got, input stream_beat_t exp);
      if (got !== exp) begin
         beat_errors++;
         $display("FAILED at %0t: beat tdata=%h tlast=%b, expected tdata=%h tlast=%b",
                  $time, got.tdata, got.tlast, exp.tdata, exp.tlast);
      end
   endtask

   task automatic check_err(input logic got, input logic exp);
      if (got !== exp) begin
         err_errors++;
         $display("FAILED at %0t: err_tvalid=%b, expected %b", $time, got, exp);
      end
   endtask

   task automatic apply_reset();
      @(posedge clk);
      reset <= 1'b1;
      repeat (10) @(posedge clk);
      reset <= 1'b0;
   endtask

   // Changed at the falling edge, away from the tready update
   task automatic set_ready(input logic rand_on, input logic level);
      @(negedge clk);
      ready_rand  = rand_on;
      ready_level = level;
   endtask

   // One frame of random bytes, status one cycle after the last byte
   task automatic send_frame(input int len, input logic bad, input logic accept);
      logic [31:0]  rnd;
      stream_beat_t exp;
      for (int i = 0; i < len; i++) begin
         rnd = $random(seed);
         @(posedge clk);
         mac_rx.data  <= rnd[7:0];
         mac_rx.valid <= 1'b1;
         if (accept) begin
            exp.tdata = rnd[7:0];
            exp.tlast = (i == len - 1);
            exp_beats.push_back(exp);
            exp_errs.push_back((i == len - 1) && bad);  // Strobe only on tlast
         end
      end
      @(posedge clk);
      mac_rx.data   <= 8'h00;
      mac_rx.valid  <= 1'b0;
      rx_good_frame <= !bad;
      rx_bad_frame  <= bad;
      @(posedge clk);
      rx_good_frame <= 1'b0;
      rx_bad_frame  <= 1'b0;
      frames_sent++;
   endtask

   task automatic wait_drain();
      int waited;
      waited = 0;
      while (exp_beats.size() != 0 && waited < DRAIN_LIMIT) begin
         @(posedge clk);
         waited++;
      end
      if (exp_beats.size() != 0) begin
         other_errors++;
         $display("Output stalled at %0t with %0d expected beats still missing",
                  $time, exp_beats.size());
         exp_beats.delete();
         exp_errs.delete();
      end
   endtask

   // Hold off the next frame until the queue has room for it
   task automatic wait_backlog();
      int waited;
      waited = 0;
      while (exp_beats.size() >= BACKLOG_LIMIT && waited < DRAIN_LIMIT) begin
         @(posedge clk);
         waited++;
      end
      if (exp_beats.size() >= BACKLOG_LIMIT) begin
         other_errors++;
         $display("Output backlog did not shrink by %0t", $time);
      end
   endtask

   task automatic single_good_frame_test();
      set_ready(1'b0, 1'b1);
      send_frame(10, 1'b0, 1'b1);
      wait_drain();
   endtask

   task automatic bad_then_good_test();
      send_frame(12, 1'b1, 1'b1);
      send_frame(8, 1'b0, 1'b1);
      wait_drain();
   endtask

   task automatic random_frames_test();
      logic [31:0] rnd;
      int          len;
      set_ready(1'b1, 1'b1);
      for (int n = 0; n < RANDOM_FRAMES; n++) begin
         rnd = $random(seed);
         len = 1 + int'(rnd % 32'd40);  // 1 to 40 bytes
         wait_backlog();
         send_frame(len, rnd[16], 1'b1);
      end
      set_ready(1'b0, 1'b1);
      wait_drain();
   endtask

   task automatic one_byte_frames_test();
      for (int n = 0; n < ONE_BYTE_FRAMES; n++) begin
         wait_backlog();
         send_frame(1, n[0], 1'b1);  // Alternate good and bad
      end
      wait_drain();
   endtask

   task automatic drop_on_threshold_test();
      int   words_written;
      int   fill;
      int   sent;
      logic accept;
      set_ready(1'b0, 1'b0);
      apply_reset();  // Stalled stream from reset on
      words_written = 0;
      fill          = 0;
      sent          = 0;
      accept        = 1'b1;
      while (accept && sent <= MAX_FILL_FRAMES) begin
         accept = fill < DATA_FIFO_DEPTH - ALMOST_FULL_MARGIN;
         send_frame(FILL_LEN, sent[0], accept);
         sent++;
         if (accept) begin
            words_written += FILL_LEN + 1;  // Bytes and marker
            fill = words_written - 1;       // First byte sits in the emitter
         end
      end
      repeat (EXTRA_DROPS) send_frame(FILL_LEN, 1'b0, 1'b0);
      set_ready(1'b0, 1'b1);
      wait_drain();
      send_frame(FILL_LEN, 1'b1, 1'b1);  // Room again after draining
      wait_drain();
   endtask

   // tready source, one update per rising edge
   initial begin : ready_driver
      logic [31:0] rnd;
      tready = 1'b1;
      forever begin
         @(posedge clk);
         if (ready_rand) begin
            rnd = $random(ready_seed);
            tready <= rnd[0];
         end else begin
            tready <= ready_level;
         end
      end
   end

   // Sampled at the falling edge where all DUT outputs are settled
   initial begin : monitor
      stream_beat_t exp_beat;
      logic         exp_err;
      forever begin
         @(negedge clk);
         if (!reset) begin
            if (tvalid && tready) begin
               if (exp_beats.size() == 0) begin
                  other_errors++;
                  $display("Unexpected beat tdata=%h at %0t with no frame pending",
                           m_beat.tdata, $time);
               end else begin
                  exp_beat = exp_beats.pop_front();
                  exp_err  = exp_errs.pop_front();
                  check_beat(m_beat, exp_beat);
                  check_err(err_tvalid, exp_err);
               end
            end else begin
               check_err(err_tvalid, 1'b0);  // No strobe without a transfer
            end
         end
      end
   end

   initial begin : watchdog
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      $display("Timeout, tests still running after %0d cycles", WATCHDOG_CYCLES);
      $display("Errors found");
      $finish;
   end

   initial begin : main
      reset         = 1'b1;
      mac_rx        = '0;
      rx_good_frame = 1'b0;
      rx_bad_frame  = 1'b0;
      apply_reset();
      single_good_frame_test();
      bad_then_good_test();
      random_frames_test();
      one_byte_frames_test();
      drop_on_threshold_test();
      $display("Frames sent: %0d, beat errors: %0d, err_tvalid errors: %0d, other errors: %0d",
               frames_sent, beat_errors, err_errors, other_errors);
      if (beat_errors + err_errors + other_errors == 0)
         $display("No errors");
      else
         $display("Errors found");
      $finish;
   end

endmodule

`default_nettype wire

// ==== build.f ====
hdl/mac_rx_pkg.sv
hdl/stream_pkg.sv
hdl/rx_frame_capture.sv
hdl/rx_sync_fifo.sv
hdl/rx_stream_emit.sv
hdl/rx_queue_top.sv
bench/tb_clock.sv
bench/tb_rx_queue.sv

// ==== hdl/mac_rx_pkg.sv ====
// MAC-side types and FIFO sizing shared by the receive capture stage and the top level
`default_nettype none

package mac_rx_pkg;

   // FIFO sizing
   localparam int DATA_FIFO_DEPTH    = 128;  // Frame bytes plus end markers
   localparam int INFO_FIFO_DEPTH    = 64;   // One status bit per frame
   localparam int ALMOST_FULL_MARGIN = 48;   // Room kept free for a frame in flight

   // Data FIFO count reaches DATA_FIFO_DEPTH, so one extra bit
   localparam int DATA_COUNT_W = $clog2(DATA_FIFO_DEPTH + 1);

   // Frame starting at or above this occupancy gets dropped
   localparam int DROP_THRESHOLD = DATA_FIFO_DEPTH - ALMOST_FULL_MARGIN;

   // One cycle of MAC receive data
   typedef struct packed {
      logic [7:0] data;   // Received byte
      logic       valid;  // High through the whole frame
   } mac_rx_beat_t;

   // Data FIFO entry
   typedef struct packed {
      logic [7:0] data;     // Frame byte, zero in a marker
      logic       is_data;  // Clear marks end of frame
   } fifo_word_t;

   // Capture FSM
   typedef enum logic [1:0] {
      CAP_IDLE   = 2'd0,  // Between frames
      CAP_ACCEPT = 2'd1,  // Writing frame bytes
      CAP_DROP   = 2'd2   // Discarding frame
   } capture_state_e;

endpackage

`default_nettype wire

// ==== hdl/rx_frame_capture.sv ====
// Receive capture stage; accepts or drops whole MAC frames and queues their bytes and status
`default_nettype none

module rx_frame_capture (
   input  wire logic                                  clk,
   input  wire logic                                  reset,
   input  wire mac_rx_pkg::mac_rx_beat_t              mac_rx,
   input  wire logic                                  rx_good_frame,
   input  wire logic                                  rx_bad_frame,
   input  wire logic [mac_rx_pkg::DATA_COUNT_W-1:0]   data_count,   // Data FIFO occupancy
   output logic                                       data_wr_en,
   output mac_rx_pkg::fifo_word_t                     data_wr_word,
   output logic                                       info_wr_en,
   output logic                                       info_wr_bad   // High for a bad frame
);

   import mac_rx_pkg::*;

   capture_state_e state, state_next;
   logic           frame_accepted;  // Last frame went into the FIFO
   logic           has_room;        // Enough space for a new frame
   logic           status_pulse;

   assign has_room     = data_count < DROP_THRESHOLD;
   assign status_pulse = rx_good_frame | rx_bad_frame;

   // Status only follows a frame that was written
   assign info_wr_en  = status_pulse & frame_accepted;
   assign info_wr_bad = rx_bad_frame;

   always_comb begin
      state_next           = state;
      data_wr_en           = 1'b0;
      data_wr_word.data    = mac_rx.data;  // Byte goes straight through
      data_wr_word.is_data = 1'b1;

      case (state)
         CAP_IDLE: begin
            if (mac_rx.valid) begin
               if (has_room) begin
                  data_wr_en = 1'b1;          // First byte, same cycle
                  state_next = CAP_ACCEPT;
               end else begin
                  state_next = CAP_DROP;      // Near full, skip whole frame
               end
            end
         end

         CAP_ACCEPT: begin
            data_wr_en = 1'b1;
            if (!mac_rx.valid) begin
               // End of run, write marker word instead
               data_wr_word.data    = 8'h00;
               data_wr_word.is_data = 1'b0;
               state_next           = CAP_IDLE;
            end
         end

         CAP_DROP: begin
            if (!mac_rx.valid)
               state_next = CAP_IDLE;
         end

         default: state_next = CAP_IDLE;
      endcase
   end

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         state          <= CAP_IDLE;
         frame_accepted <= 1'b0;
      end else begin
         state <= state_next;
         if (state == CAP_IDLE && mac_rx.valid)
            frame_accepted <= has_room;  // Decided at frame start
         else if (status_pulse)
            frame_accepted <= 1'b0;      // One status per frame
      end
   end

   // Status comes after the run, never inside it
   // The marker cycle still shows CAP_ACCEPT, hence the valid term
   assert property (@(posedge clk) disable iff (reset)
      (state == CAP_ACCEPT && mac_rx.valid) |-> !status_pulse)
      else $error("Status pulse inside an accepted frame");

   assert property (@(posedge clk) disable iff (reset)
      !(rx_good_frame && rx_bad_frame))
      else $error("Good and bad frame status together");

endmodule

`default_nettype wire

// ==== hdl/rx_queue_top.sv ====
// Receive queue top level; joins capture, data and status FIFOs and the stream emitter
`default_nettype none

module rx_queue_top (
   input  wire logic                       clk,
   input  wire logic                       reset,
   input  wire mac_rx_pkg::mac_rx_beat_t   mac_rx,
   input  wire logic                       rx_good_frame,
   input  wire logic                       rx_bad_frame,
   input  wire logic                       tready,
   output stream_pkg::stream_beat_t        m_beat,
   output logic                            tvalid,
   output logic                            err_tvalid
);

   import mac_rx_pkg::*;

   // Data FIFO side
   logic                    data_wr_en;
   fifo_word_t              data_wr_word;
   logic                    data_rd_en;
   logic                    data_empty;
   fifo_word_t              data_head;
   logic [DATA_COUNT_W-1:0] data_count;  // Drives the drop decision

   // Status FIFO side
   logic                    info_wr_en;
   logic                    info_wr_bad;
   logic                    info_rd_en;
   logic                    info_empty;
   logic                    info_bad;

   rx_frame_capture rx_frame_capture_i (
      .clk, .reset, .mac_rx, .rx_good_frame, .rx_bad_frame,
      .data_count, .data_wr_en, .data_wr_word, .info_wr_en, .info_wr_bad
   );

   rx_sync_fifo #(.WIDTH($bits(fifo_word_t)), .DEPTH(DATA_FIFO_DEPTH)) data_fifo (
      .clk, .reset,
      .wr_en(data_wr_en), .wr_data(data_wr_word),
      .rd_en(data_rd_en), .rd_data(data_head),
      .empty(data_empty), .full(), .count(data_count)
   );

   rx_sync_fifo #(.WIDTH(1), .DEPTH(INFO_FIFO_DEPTH)) info_fifo (
      .clk, .reset,
      .wr_en(info_wr_en), .wr_data(info_wr_bad),
      .rd_en(info_rd_en), .rd_data(info_bad),
      .empty(info_empty), .full(), .count()
   );

   rx_stream_emit rx_stream_emit_i (
      .clk, .reset, .data_empty, .data_head, .data_rd_en,
      .info_empty, .info_bad, .info_rd_en, .tready, .m_beat, .tvalid, .err_tvalid
   );

endmodule

`default_nettype wire

// ==== hdl/rx_stream_emit.sv ====
// Stream emitter; replays queued frame bytes with tlast and a per-frame error strobe
`default_nettype none

module rx_stream_emit (
   input  wire logic                    clk,
   input  wire logic                    reset,
   input  wire logic                    data_empty,
   input  wire mac_rx_pkg::fifo_word_t  data_head,   // Data FIFO head word
   output logic                         data_rd_en,
   input  wire logic                    info_empty,
   input  wire logic                    info_bad,    // Head status, high for bad frame
   output logic                         info_rd_en,
   input  wire logic                    tready,
   output stream_pkg::stream_beat_t     m_beat,
   output logic                         tvalid,
   output logic                         err_tvalid
);

   import stream_pkg::*;

   emit_state_e state, state_next;
   logic [7:0]  hold_byte;   // Byte waiting for its successor
   logic        beat_last;
   logic        head_is_data;

   assign head_is_data = !data_empty && data_head.is_data;

   assign m_beat.tdata = hold_byte;
   assign m_beat.tlast = beat_last;

   always_comb begin
      state_next = state;
      data_rd_en = 1'b0;
      info_rd_en = 1'b0;
      tvalid     = 1'b0;
      beat_last  = 1'b0;
      err_tvalid = 1'b0;

      case (state)
         EM_LOAD: begin
            // Prime holding register, no tready needed
            if (!data_empty) begin
               data_rd_en = 1'b1;
               state_next = EM_STREAM;
            end
         end

         EM_STREAM: begin
            if (head_is_data) begin
               tvalid     = 1'b1;          // More data behind, not last
               data_rd_en = tready;        // Head slides into holding register
            end else if (!data_empty) begin
               state_next = EM_STATUS;     // Marker at head, held byte is last
            end
         end

         EM_STATUS: begin
            if (!info_empty) begin
               tvalid    = 1'b1;
               beat_last = 1'b1;
               if (tready) begin
                  data_rd_en = 1'b1;       // Drop marker
                  info_rd_en = 1'b1;       // Drop status
                  err_tvalid = info_bad;
                  state_next = EM_LOAD;
               end
            end
         end

         default: state_next = EM_LOAD;
      endcase
   end

   // Holding register, loaded only from data words
   always_ff @(posedge clk) begin
      if (data_rd_en && data_head.is_data)
         hold_byte <= data_head.data;
   end

   always_ff @(posedge clk or posedge reset) begin
      if (reset)
         state <= EM_LOAD;
      else
         state <= state_next;
   end

   // Stalled beat is held unchanged until taken
   assert property (@(posedge clk) disable iff (reset)
      (tvalid && !tready) |=> (tvalid && $stable(m_beat)))
      else $error("Stream beat changed while stalled");

endmodule

`default_nettype wire

// ==== hdl/rx_sync_fifo.sv ====
// Single-clock first-word-fall-through FIFO with occupancy count for the receive queue
`default_nettype none

module rx_sync_fifo #(
   parameter int WIDTH = 9,    // Word width
   parameter int DEPTH = 128   // Entries
) (
   input  wire logic                       clk,
   input  wire logic                       reset,
   input  wire logic                       wr_en,
   input  wire logic [WIDTH-1:0]           wr_data,
   input  wire logic                       rd_en,
   output logic      [WIDTH-1:0]           rd_data,  // Head word, no read latency
   output logic                            empty,
   output logic                            full,
   output logic      [$clog2(DEPTH+1)-1:0] count
);

   logic [WIDTH-1:0]           mem [DEPTH];
   logic [$clog2(DEPTH)-1:0]   wr_ptr;
   logic [$clog2(DEPTH)-1:0]   rd_ptr;
   logic                       do_wr;
   logic                       do_rd;

   assign empty = (count == 0);
   assign full  = (count == DEPTH);

   assign do_wr = wr_en & ~full;   // Overflow dropped
   assign do_rd = rd_en & ~empty;  // Underflow ignored

   assign rd_data = mem[rd_ptr];   // Fall-through head

   // Storage
   always_ff @(posedge clk) begin
      if (do_wr)
         mem[wr_ptr] <= wr_data;
   end

   // Pointers and occupancy
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_wr) begin
            if (wr_ptr == DEPTH - 1)
               wr_ptr <= '0;
            else
               wr_ptr <= wr_ptr + 1'b1;
         end
         if (do_rd) begin
            if (rd_ptr == DEPTH - 1)
               rd_ptr <= '0;
            else
               rd_ptr <= rd_ptr + 1'b1;
         end
         case ({do_wr, do_rd})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;  // Idle or write-and-read
         endcase
      end
   end

   // Producer must keep frames within the free space
   assert property (@(posedge clk) disable iff (reset)
      wr_en |-> !full)
      else $error("Write to full FIFO");

   assert property (@(posedge clk) disable iff (reset)
      rd_en |-> !empty)
      else $error("Read from empty FIFO");

endmodule

`default_nettype wire

// ==== hdl/stream_pkg.sv ====
// Stream-side types for the byte-wide output of the receive queue
`default_nettype none

package stream_pkg;

   // One beat on the output stream
   typedef struct packed {
      logic [7:0] tdata;  // Frame byte
      logic       tlast;  // Last byte of frame
   } stream_beat_t;

   // Emitter FSM
   // EM_LOAD   fetch first byte of a frame into the holding register
   // EM_STREAM offer held byte while the head is more frame data
   // EM_STATUS offer final byte once the frame status is queued
   typedef enum logic [1:0] {
      EM_LOAD   = 2'd0,
      EM_STREAM = 2'd1,
      EM_STATUS = 2'd2
   } emit_state_e;

endpackage

`default_nettype wire
